//--- cal_top.f
rtl/cal_pkg.sv
rtl/cal_display_pkg.sv
rtl/cal_if.sv
rtl/cal_sequencer.sv
rtl/cal_operand_entry.sv
rtl/cal_execute.sv
rtl/cal_bcd_convert.sv
rtl/cal_display_scan.sv
rtl/cal_top.sv
testbench/tb_clock_gen.sv
testbench/tb_cal_top.sv

//--- rtl/cal_bcd_convert.sv
// magnitude must not exceed 999; a new done restarts the conversion and drops the previous one
`timescale 1ns/1ps

module cal_bcd_convert import cal_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    cal_result_if.sink res,
    output bcd3_t      bcd_digits,
    output logic       conv_done
);

    logic [$bits(bcd3_t)+$bits(mag_t)-1:0] shift_q;
    logic [$bits(bcd3_t)+$bits(mag_t)-1:0] adjusted;
    logic [3:0]                            iter_cnt;
    logic                                  busy;

    // add 3 to each bcd nibble of 5 or more before the shift
    always_comb begin
        adjusted = shift_q;
        for (int n = 0; n < $bits(bcd3_t) / 4; n++) begin
            if (shift_q[$bits(mag_t) + 4*n +: 4] >= 4'd5) begin
                adjusted[$bits(mag_t) + 4*n +: 4] = shift_q[$bits(mag_t) + 4*n +: 4] + 4'd3;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy      <= 1'b0;
            iter_cnt  <= '0;
            conv_done <= 1'b0;
        end else begin
            conv_done <= 1'b0;
            if (res.done) begin
                busy     <= 1'b1;
                iter_cnt <= '0;
            end else if (busy) begin
                iter_cnt <= iter_cnt + 1'b1;
                if (iter_cnt == 4'($bits(mag_t) - 1)) begin
                    busy      <= 1'b0;
                    conv_done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (res.done) begin
            shift_q <= {{$bits(bcd3_t){1'b0}}, res.magnitude};
        end else if (busy) begin
            shift_q <= adjusted << 1;
        end
    end

    assign bcd_digits = shift_q[$bits(shift_q)-1 -: $bits(bcd3_t)];

endmodule

//--- rtl/cal_display_pkg.sv
// segment patterns are active low with bit 0 as the decimal point; unknown codes show blank
package cal_display_pkg;

    typedef logic [7:0] seg_t;
    typedef logic [1:0] digit_sel_t;

    localparam logic [3:0] CODE_BLANK = 4'd10;
    localparam logic [3:0] CODE_MINUS = 4'd11;
    // position changes every 2**SCAN_DIV_BITS clocks
    localparam int SCAN_DIV_BITS = 4;
    localparam seg_t SEG_BLANK = 8'b1111_1111;

    function automatic seg_t seg_encode(input logic [3:0] code);
        case (code)
            4'd0:       return 8'b0000_0011;
            4'd1:       return 8'b1001_1111;
            4'd2:       return 8'b0010_0101;
            4'd3:       return 8'b0000_1101;
            4'd4:       return 8'b1001_1001;
            4'd5:       return 8'b0100_1001;
            4'd6:       return 8'b0100_0001;
            4'd7:       return 8'b0001_1111;
            4'd8:       return 8'b0000_0001;
            4'd9:       return 8'b0001_1001;
            CODE_MINUS: return 8'b1111_1101;
            default:    return SEG_BLANK;
        endcase
    endfunction

endpackage

//--- rtl/cal_display_scan.sv
// digit_ctrl is active low; the display stays dark while computing and after an error
`timescale 1ns/1ps

module cal_display_scan import cal_pkg::*; import cal_display_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  seq_state_e   state,
    input  digit_t [2:0] cur_digits,
    input  logic         cur_sign,
    cal_result_if.sink   res,
    input  bcd3_t        bcd_digits,
    output logic [3:0]   digit_ctrl,
    output seg_t         digit_seg
);

    logic [SCAN_DIV_BITS+$bits(digit_sel_t)-1:0] scan_cnt;
    digit_sel_t                                  pos;
    digit_sel_t                                  msd;
    digit_t [3:0]                                codes;
    digit_t [2:0]                                res_digits;
    logic                                        in_entry;
    logic                                        show_result;

    always_ff @(posedge clk) begin
        if (rst) begin
            scan_cnt <= '0;
        end else begin
            scan_cnt <= scan_cnt + 1'b1;
        end
    end

    assign pos         = scan_cnt[SCAN_DIV_BITS +: $bits(digit_sel_t)];
    assign res_digits  = bcd_digits;
    assign in_entry    = (state == SEQ_INPUT_A) || (state == SEQ_INPUT_B);
    assign show_result = (state == SEQ_DISPLAY) && !res.error;
    // highest digit left after blanking, units always shown
    assign msd = (res_digits[2] != '0) ? 2'd2 : (res_digits[1] != '0) ? 2'd1 : 2'd0;

    always_comb begin
        codes = {4{CODE_BLANK}};
        if (in_entry) begin
            codes[2:0] = cur_digits;
            codes[3]   = cur_sign ? CODE_MINUS : CODE_BLANK;
        end else if (show_result) begin
            for (int i = 0; i < 3; i++) begin
                if (i <= msd) codes[i] = res_digits[i];
            end
            if (res.negative) codes[msd + 2'd1] = CODE_MINUS;
        end
    end

    assign digit_ctrl = (in_entry || show_result) ? ~(4'b0001 << pos) : 4'b1111;
    assign digit_seg  = seg_encode(codes[pos]);

endmodule

//--- rtl/cal_execute.sv
// done follows start by exactly 6 clocks; divide truncates toward zero, divide by zero is an error
`timescale 1ns/1ps

module cal_execute import cal_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic [OP_WIDTH-1:0] switches,
    cal_operand_if.sink         ops,
    cal_result_if.source        res
);

    exe_state_e                           state;
    logic [$clog2(INIT_CYCLES)-1:0]       init_cnt;
    logic [OP_WIDTH-1:0]                  op_pick;
    logic [OP_WIDTH-1:0]                  op_sel;
    digit_t [1:0][2:0]                    dig;
    logic [1:0]                           neg_in;
    operand_t                             part_tens [2];
    operand_t                             part_hund [2];
    operand_t                             part_rest [2];
    operand_t                             sum_hi [2];
    operand_t                             mag_in [2];
    operand_t                             opnd [2];
    operand_t                             divisor;
    logic signed [2*$bits(operand_t)-1:0] alu_out;
    logic signed [2*$bits(operand_t)-1:0] alu_abs;
    logic                                 div_zero;
    logic                                 calc_err;

    // isolate the lowest set switch
    assign op_pick = switches & (~switches + 1'b1);
    assign dig     = {ops.b_digits, ops.a_digits};
    assign neg_in  = {ops.b_sign, ops.a_sign};

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= EXE_IDLE;
            init_cnt <= '0;
        end else begin
            case (state)
                EXE_IDLE: begin
                    init_cnt <= '0;
                    if (ops.start) state <= EXE_INIT;
                end
                EXE_INIT: begin
                    init_cnt <= init_cnt + 1'b1;
                    if (init_cnt == $bits(init_cnt)'(INIT_CYCLES - 1)) state <= EXE_CALC;
                end
                EXE_CALC: state <= EXE_DONE;
                default:  state <= EXE_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (ops.start) op_sel <= op_pick;
    end

    // x10 = x8 + x2, x100 = x64 + x32 + x4
    always_ff @(posedge clk) begin
        if (state == EXE_INIT) begin
            for (int i = 0; i < 2; i++) begin
                case (init_cnt)
                    0: begin
                        part_tens[i] <= (operand_t'(dig[i][1]) << 3) + (operand_t'(dig[i][1]) << 1);
                        part_hund[i] <= (operand_t'(dig[i][2]) << 6) + (operand_t'(dig[i][2]) << 5);
                        part_rest[i] <= operand_t'(dig[i][0]) + (operand_t'(dig[i][2]) << 2);
                    end
                    1:       sum_hi[i] <= part_tens[i] + part_hund[i];
                    2:       mag_in[i] <= sum_hi[i] + part_rest[i];
                    default: opnd[i] <= neg_in[i] ? -mag_in[i] : mag_in[i];
                endcase
            end
        end
    end

    always_comb begin
        div_zero = op_sel[OP_DIV] && (opnd[1] == '0);
        divisor  = (opnd[1] == '0) ? operand_t'(1) : opnd[1];
        alu_out  = '0;
        if (op_sel[OP_ADD]) alu_out = opnd[0] + opnd[1];
        else if (op_sel[OP_SUB]) alu_out = opnd[0] - opnd[1];
        else if (op_sel[OP_MUL]) alu_out = opnd[0] * opnd[1];
        else if (op_sel[OP_DIV]) alu_out = opnd[0] / divisor;
        alu_abs  = (alu_out < 0) ? -alu_out : alu_out;
        calc_err = (op_sel == '0) || div_zero || (alu_abs > DISPLAY_MAX);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            res.error <= 1'b0;
        end else if (state == EXE_CALC) begin
            res.error <= calc_err;
        end
    end

    always_ff @(posedge clk) begin
        if (state == EXE_CALC) begin
            res.magnitude <= calc_err ? '0 : mag_t'(alu_abs);
            res.negative  <= !calc_err && (alu_out < 0);
        end
    end

    assign res.done = (state == EXE_DONE);

    a_done_pulse: assert property (
        @(posedge clk) disable iff (rst) res.done |=> !res.done
    ) else $error("execute done held for more than one cycle");

endmodule

//--- rtl/cal_if.sv
// start and done are one-cycle pulses; the fields they qualify are held until the next pulse
`timescale 1ns/1ps

interface cal_operand_if import cal_pkg::*; ();

    digit_t [2:0] a_digits;
    logic         a_sign;
    digit_t [2:0] b_digits;
    logic         b_sign;
    logic         start;

    modport source (output a_digits, a_sign, b_digits, b_sign, start);
    modport sink (input a_digits, a_sign, b_digits, b_sign, start);

endinterface

interface cal_result_if import cal_pkg::*; ();

    // magnitude is zero and negative low whenever error is set
    mag_t magnitude;
    logic negative;
    logic error;
    logic done;

    modport source (output magnitude, negative, error, done);
    modport sink (input magnitude, negative, error, done);

endinterface

//--- rtl/cal_operand_entry.sv
// cursor stops at digit 0 and at the sign without wrapping; edits are ignored outside entry states
`timescale 1ns/1ps

module cal_operand_entry import cal_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [BUTTON_WIDTH-1:0] button,
    input  seq_state_e              state,
    cal_operand_if.source           ops,
    output digit_t [2:0]            cur_digits,
    output logic                    cur_sign,
    output logic                    btn_mid
);

    typedef enum logic [1:0] {CUR_DIGIT0, CUR_DIGIT1, CUR_DIGIT2, CUR_SIGN} cursor_e;

    cursor_e                 cursor;
    logic [BUTTON_WIDTH-1:0] btn_qual;
    logic                    in_entry;
    logic                    clear;
    logic                    confirm_a;
    logic                    confirm_b;

    function automatic digit_t step_digit(input digit_t d, input logic up);
        if (up) begin
            return (d == 4'd9) ? 4'd0 : d + 4'd1;
        end
        return (d == 4'd0) ? 4'd9 : d - 4'd1;
    endfunction

    // a press counts only if no lower-indexed button is held
    always_comb begin
        btn_qual[BTN_LEFT] = button[BTN_LEFT];
        for (int i = 1; i < BUTTON_WIDTH; i++) begin
            btn_qual[i] = button[i] && !(|(button & BUTTON_WIDTH'((1 << i) - 1)));
        end
    end

    assign btn_mid   = btn_qual[BTN_MID];
    assign in_entry  = (state == SEQ_INPUT_A) || (state == SEQ_INPUT_B);
    assign confirm_a = btn_mid && (state == SEQ_INPUT_A);
    assign confirm_b = btn_mid && (state == SEQ_INPUT_B);
    // every mid that leads into A or B starts the next entry from zero
    assign clear     = confirm_a || (btn_mid && state == SEQ_DISPLAY);
    assign ops.start = confirm_b;

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            cursor     <= CUR_DIGIT0;
            cur_digits <= '0;
            cur_sign   <= 1'b0;
        end else if (in_entry) begin
            if (btn_qual[BTN_LEFT] && cursor != CUR_SIGN) begin
                cursor <= cursor_e'(cursor + 2'd1);
            end else if (btn_qual[BTN_RIGHT] && cursor != CUR_DIGIT0) begin
                cursor <= cursor_e'(cursor - 2'd1);
            end
            if (btn_qual[BTN_UP] || btn_qual[BTN_DOWN]) begin
                if (cursor == CUR_SIGN) begin
                    cur_sign <= !cur_sign;
                end else begin
                    cur_digits[cursor] <= step_digit(cur_digits[cursor], btn_qual[BTN_UP]);
                end
            end
        end
    end

    // operand copies held until the next confirmation
    always_ff @(posedge clk) begin
        if (confirm_a) begin
            ops.a_digits <= cur_digits;
            ops.a_sign   <= cur_sign;
        end
        if (confirm_b) begin
            ops.b_digits <= cur_digits;
            ops.b_sign   <= cur_sign;
        end
    end

    a_btn_onehot: assert property (
        @(posedge clk) disable iff (rst) $onehot0(btn_qual)
    ) else $error("more than one qualified button: %b", btn_qual);

endmodule

//--- rtl/cal_pkg.sv
// operands are three decimal digits plus sign; any result beyond +/-999 is treated as an error
package cal_pkg;

    typedef logic [3:0] digit_t;
    typedef logic signed [15:0] operand_t;
    typedef logic [9:0] mag_t;
    typedef logic [11:0] bcd3_t;

    // push buttons, lower index wins
    localparam int BUTTON_WIDTH = 5;
    localparam int BTN_LEFT     = 0;
    localparam int BTN_RIGHT    = 1;
    localparam int BTN_UP       = 2;
    localparam int BTN_DOWN     = 3;
    localparam int BTN_MID      = 4;

    // operation switches, lowest set switch selects
    localparam int OP_WIDTH = 4;
    localparam int OP_ADD   = 0;
    localparam int OP_SUB   = 1;
    localparam int OP_MUL   = 2;
    localparam int OP_DIV   = 3;

    localparam int DISPLAY_MAX = 999;
    // steps of the decimal to binary adder tree
    localparam int INIT_CYCLES = 4;

    typedef enum logic [2:0] {
        SEQ_INPUT_A,
        SEQ_INPUT_B,
        SEQ_EXECUTE,
        SEQ_CONVERT,
        SEQ_DISPLAY
    } seq_state_e;

    typedef enum logic [1:0] {EXE_IDLE, EXE_INIT, EXE_CALC, EXE_DONE} exe_state_e;

endpackage

//--- rtl/cal_sequencer.sv
// mid is the only user input it reacts to; execute and convert run to completion once started
`timescale 1ns/1ps

module cal_sequencer import cal_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       btn_mid,
    input  logic       exe_done_pulse,
    input  logic       conv_done,
    output seq_state_e state
);

    seq_state_e next_state;

    always_comb begin
        next_state = state;
        case (state)
            SEQ_INPUT_A: if (btn_mid) next_state = SEQ_INPUT_B;
            SEQ_INPUT_B: if (btn_mid) next_state = SEQ_EXECUTE;
            SEQ_EXECUTE: if (exe_done_pulse) next_state = SEQ_CONVERT;
            SEQ_CONVERT: if (conv_done) next_state = SEQ_DISPLAY;
            SEQ_DISPLAY: if (btn_mid) next_state = SEQ_INPUT_A;
            default:     next_state = SEQ_INPUT_A;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= SEQ_INPUT_A;
        end else begin
            state <= next_state;
        end
    end

    a_state_legal: assert property (
        @(posedge clk) disable iff (rst)
        state inside {SEQ_INPUT_A, SEQ_INPUT_B, SEQ_EXECUTE, SEQ_CONVERT, SEQ_DISPLAY}
    ) else $error("sequencer in illegal state %0d", state);

endmodule

//--- rtl/cal_top.sv
// buttons must arrive debounced as one-cycle pulses; single clock domain, no bus interface
`timescale 1ns/1ps

module cal_top import cal_pkg::*; import cal_display_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [BUTTON_WIDTH-1:0] button,
    input  logic [OP_WIDTH-1:0]     switches,
    output logic [3:0]              digit_ctrl,
    output seg_t                    digit_seg,
    output logic                    exe_done,
    output logic                    error
);

    seq_state_e   seq_state;
    digit_t [2:0] cur_digits;
    logic         cur_sign;
    logic         btn_mid;
    bcd3_t        bcd_digits;
    logic         conv_done;

    cal_operand_if ops_if ();
    cal_result_if  res_if ();

    cal_sequencer u_sequencer (
        .clk            (clk),
        .rst            (rst),
        .btn_mid        (btn_mid),
        .exe_done_pulse (res_if.done),
        .conv_done      (conv_done),
        .state          (seq_state)
    );

    cal_operand_entry u_operand_entry (
        .clk        (clk),
        .rst        (rst),
        .button     (button),
        .state      (seq_state),
        .ops        (ops_if.source),
        .cur_digits (cur_digits),
        .cur_sign   (cur_sign),
        .btn_mid    (btn_mid)
    );

    cal_execute u_execute (
        .clk      (clk),
        .rst      (rst),
        .switches (switches),
        .ops      (ops_if.sink),
        .res      (res_if.source)
    );

    cal_bcd_convert u_bcd_convert (
        .clk        (clk),
        .rst        (rst),
        .res        (res_if.sink),
        .bcd_digits (bcd_digits),
        .conv_done  (conv_done)
    );

    cal_display_scan u_display_scan (
        .clk        (clk),
        .rst        (rst),
        .state      (seq_state),
        .cur_digits (cur_digits),
        .cur_sign   (cur_sign),
        .res        (res_if.sink),
        .bcd_digits (bcd_digits),
        .digit_ctrl (digit_ctrl),
        .digit_seg  (digit_seg)
    );

    assign exe_done = (seq_state == SEQ_DISPLAY);
    assign error    = res_if.error;

endmodule

//--- run_sim.sh
#!/bin/sh
# build and run with Verilator; the result comes from the pass message in the log
set -u
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_cal_top -f cal_top.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_cal_top > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test completed successfully" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

//--- testbench/tb_cal_top.sv
// buttons are driven as single-cycle pulses; expected results must lie within +/-999
`timescale 1ns/1ps

module tb_cal_top import cal_pkg::*; import cal_display_pkg::*; ();

    localparam int IDLE_CYCLES  = 1;
    localparam int SCAN_TIMEOUT = 200;
    localparam int DONE_TIMEOUT = 100;

    logic                    clk;
    logic                    rst;
    logic [BUTTON_WIDTH-1:0] button;
    logic [OP_WIDTH-1:0]     switches;
    logic [3:0]              digit_ctrl;
    seg_t                    digit_seg;
    logic                    exe_done;
    logic                    error;
    int                      errors = 0;
    int                      timeouts = 0;
    integer                  seed;

    tb_clock_gen #(.PERIOD_NS(8), .RESET_CYCLES(8)) u_clock_gen (.clk(clk), .rst(rst));

    cal_top u_cal_top (
        .clk        (clk),
        .rst        (rst),
        .button     (button),
        .switches   (switches),
        .digit_ctrl (digit_ctrl),
        .digit_seg  (digit_seg),
        .exe_done   (exe_done),
        .error      (error)
    );

    task automatic finish_run();
        $display("checks failed: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    endtask

    task automatic abort_on_timeout(input string what);
        timeouts++;
        $display("timeout while waiting for %s", what);
        finish_run();
    endtask

    function automatic int rand_range(input int lo, input int hi);
        int span;
        span = hi - lo + 1;
        return lo + int'($unsigned($random(seed)) % span);
    endfunction

    function automatic logic [BUTTON_WIDTH-1:0] button_mask(input int idx);
        return BUTTON_WIDTH'(1 << idx);
    endfunction

    // expected value and error flag, straight from the calculator rules
    function automatic bit calc_expected(input int a, input int b,
                                         input logic [OP_WIDTH-1:0] sw, output int value);
        value = 0;
        if (sw[OP_ADD]) value = a + b;
        else if (sw[OP_SUB]) value = a - b;
        else if (sw[OP_MUL]) value = a * b;
        else if (sw[OP_DIV]) begin
            if (b == 0) return 1'b1;
            value = a / b;
        end else return 1'b1;
        return (value > DISPLAY_MAX) || (value < -DISPLAY_MAX);
    endfunction

    // four display codes, position 3 first
    function automatic logic [15:0] codes_for_value(input int value);
        int         mag;
        int         top;
        logic [3:0] c [4];
        mag = (value < 0) ? -value : value;
        c[0] = 4'(mag % 10);
        c[1] = 4'((mag / 10) % 10);
        c[2] = 4'(mag / 100);
        c[3] = CODE_BLANK;
        top = (c[2] != 0) ? 2 : (c[1] != 0) ? 1 : 0;
        for (int i = top + 1; i < 3; i++) c[i] = CODE_BLANK;
        if (value < 0) c[top + 1] = CODE_MINUS;
        return {c[3], c[2], c[1], c[0]};
    endfunction

    function automatic logic [3:0] decode_seg(input seg_t seg);
        for (int c = 0; c <= 11; c++) begin
            if (seg_encode(4'(c)) == seg) return 4'(c);
        end
        return 4'hf;
    endfunction

    task automatic press(input logic [BUTTON_WIDTH-1:0] mask);
        @(posedge clk);
        #1 button = mask;
        @(posedge clk);
        #1 button = '0;
        repeat (IDLE_CYCLES) @(posedge clk);
    endtask

    task automatic capture_position(input int p, output logic [3:0] code);
        int waited;
        waited = 0;
        @(negedge clk);
        while (digit_ctrl !== ~(4'b0001 << p)) begin
            if (waited == SCAN_TIMEOUT) abort_on_timeout("display scan position");
            waited++;
            @(negedge clk);
        end
        code = decode_seg(digit_seg);
    endtask

    task automatic compare_display(input string name, input logic [15:0] exp_codes);
        logic [15:0] got;
        for (int p = 0; p < 4; p++) capture_position(p, got[4*p +: 4]);
        if (got !== exp_codes) begin
            errors++;
            $display("[FAIL] %s: expected %h, actual %h", name, exp_codes, got);
        end
    endtask

    // a full scan period must stay dark
    task automatic expect_dark(input string name);
        logic [3:0] seen;
        seen = 4'hf;
        repeat (4 << SCAN_DIV_BITS) begin
            @(negedge clk);
            if (digit_ctrl !== 4'hf) seen = digit_ctrl;
        end
        if (seen !== 4'hf) begin
            errors++;
            $display("[FAIL] %s digit_ctrl: expected %h, actual %h", name, 4'hf, seen);
        end
    endtask

    task automatic enter_operand(input int value);
        int mag;
        int digit;
        mag = (value < 0) ? -value : value;
        for (int i = 0; i < 3; i++) begin
            digit = mag % 10;
            mag = mag / 10;
            if (digit > 5) repeat (10 - digit) press(button_mask(BTN_DOWN));
            else repeat (digit) press(button_mask(BTN_UP));
            press(button_mask(BTN_LEFT));
        end
        if (value < 0) press(button_mask(BTN_UP));
        press(button_mask(BTN_MID));
    endtask

    task automatic verify_result(input string name, input int a, input int b,
                                 input logic [OP_WIDTH-1:0] sw);
        int value;
        bit exp_err;
        int waited;
        exp_err = calc_expected(a, b, sw, value);
        waited = 0;
        while (exe_done !== 1'b1) begin
            if (waited == DONE_TIMEOUT) abort_on_timeout("exe_done");
            waited++;
            @(negedge clk);
        end
        if (error !== exp_err) begin
            errors++;
            $display("[FAIL] %s error flag: expected %0b, actual %0b", name, exp_err, error);
        end
        if (exp_err) expect_dark(name);
        else compare_display(name, codes_for_value(value));
    endtask

    task automatic return_to_entry(input string name);
        press(button_mask(BTN_MID));
        @(negedge clk);
        if (exe_done !== 1'b0) begin
            errors++;
            $display("[FAIL] %s exe_done after mid: expected 0, actual %b", name, exe_done);
        end
        compare_display({name, " cleared"}, {CODE_BLANK, 4'd0, 4'd0, 4'd0});
    endtask

    task automatic run_calc(input string name, input int a, input int b,
                            input logic [OP_WIDTH-1:0] sw);
        @(posedge clk);
        #1 switches = sw;
        enter_operand(a);
        enter_operand(b);
        verify_result(name, a, b, sw);
        return_to_entry(name);
    endtask

    initial begin
        int waited;
        int a;
        int b;
        button   = '0;
        switches = '0;
        seed     = 79;
        waited   = 0;
        while (rst !== 1'b0) begin
            if (waited == 100) abort_on_timeout("reset release");
            waited++;
            @(negedge clk);
        end

        if (exe_done !== 1'b0 || error !== 1'b0) begin
            errors++;
            $display("[FAIL] reset flags: expected 00, actual %b%b", exe_done, error);
        end
        compare_display("reset display", {CODE_BLANK, 4'd0, 4'd0, 4'd0});

        // editing: wrap both ways, cursor moves, sign toggle, up beats down
        press(button_mask(BTN_DOWN));
        compare_display("wrap 0 to 9", {CODE_BLANK, 4'd0, 4'd0, 4'd9});
        press(button_mask(BTN_UP));
        compare_display("wrap 9 to 0", {CODE_BLANK, 4'd0, 4'd0, 4'd0});
        press(button_mask(BTN_LEFT));
        press(button_mask(BTN_UP));
        compare_display("cursor left", {CODE_BLANK, 4'd0, 4'd1, 4'd0});
        press(button_mask(BTN_RIGHT));
        press(button_mask(BTN_UP) | button_mask(BTN_DOWN));
        compare_display("up and down", {CODE_BLANK, 4'd0, 4'd1, 4'd1});
        repeat (3) press(button_mask(BTN_LEFT));
        press(button_mask(BTN_UP));
        compare_display("sign minus", {CODE_MINUS, 4'd0, 4'd1, 4'd1});
        @(posedge clk);
        #1 switches = 4'b0001;
        press(button_mask(BTN_MID));
        enter_operand(25);
        verify_result("edited add", -11, 25, 4'b0001);
        return_to_entry("edited add");

        for (int i = 0; i < 6; i++) begin
            a = rand_range(-499, 499);
            b = rand_range(-499, 499);
            run_calc($sformatf("add/sub %0d", i), a, b, (i % 2 == 0) ? 4'b0001 : 4'b0010);
        end
        run_calc("lowest switch", 100, 250, 4'b0110);

        run_calc("mul negative", -9, 9, 4'b0100);
        run_calc("div truncate", -7, 2, 4'b1000);
        run_calc("div neg divisor", 7, -2, 4'b1000);
        run_calc("div exact", 999, -3, 4'b1000);
        for (int i = 0; i < 3; i++) begin
            a = rand_range(-31, 31);
            b = rand_range(-31, 31);
            run_calc($sformatf("mul %0d", i), a, b, 4'b0100);
            a = rand_range(-999, 999);
            b = rand_range(1, 40);
            if (rand_range(0, 1) == 1) b = -b;
            run_calc($sformatf("div %0d", i), a, b, 4'b1000);
        end

        run_calc("div by zero", 5, 0, 4'b1000);
        run_calc("no switch", 3, 4, 4'b0000);
        run_calc("product overflow", 40, -30, 4'b0100);
        run_calc("after errors", 123, -456, 4'b0001);

        finish_run();
    end

endmodule

//--- testbench/tb_clock_gen.sv
// clock runs from time zero; reset is released once, 1 ns after the last reset edge
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst = 1'b0;
    end

endmodule
